// ==== logic/mmi_read_resp.sv ====
////////////////////////////////////////////////////////////
// Register read port
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mmi_read_resp
    import symb_rate_pkg::*;
(
    input  var logic                   clk_mmi,
    input  var logic                   sresetn_mmi,
    input  var mmi_req_t               mmi_req,
    output var logic                   arready,
    input  var logic                   rready,
    input  var symb_cfg_t              symb_cfg,
    input  var logic [MMI_DATA_NB-1:0] symb_count,
    output var mmi_rsp_t               mmi_rsp
);

    logic                   rvalid_q;
    logic [MMI_DATA_NB-1:0] rdata_q;
    logic [MMI_DATA_NB-1:0] rd_mux;
    logic                   rd_take;

    // One read in flight, freed by rready
    assign arready = !rvalid_q || rready;
    assign rd_take = mmi_req.arvalid && arready;

    ////////////////////////////////////////////////////////////
    // Address decode

    always_comb begin
        case (mmi_req.raddr)
            ADDR_MODULE_VERSION: rd_mux = MODULE_VERSION;
            ADDR_SYMB_RATE_SEL:  rd_mux = MMI_DATA_NB'(symb_cfg.rate_sel);
            ADDR_SYMB_RATE:      rd_mux = symb_cfg.rate_msps;
            ADDR_SYMB_COUNT:     rd_mux = symb_count;
            // Unmapped reads as zero
            default:             rd_mux = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Response

    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            rvalid_q <= 1'b0;
        end else if (rd_take) begin
            rvalid_q <= 1'b1;
        end else if (rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Snapshot of the request cycle
    always_ff @(posedge clk_mmi) begin
        if (rd_take) begin
            rdata_q <= rd_mux;
        end
    end

    assign mmi_rsp = '{rvalid: rvalid_q, rdata: rdata_q};

    // Pending response only drops after rready
    assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi)
        rvalid_q && !rready |=> rvalid_q && $stable(rdata_q));

endmodule

`default_nettype wire

// ==== logic/symb_rate_divider_top.sv ====
////////////////////////////////////////////////////////////
// TX symbol rate divider top
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module symb_rate_divider_top
    import symb_rate_pkg::*;
#(
    parameter int             SYMB_RATE_MSPS [NUM_SYMB_RATES] = '{125, 250, 500},
    parameter symb_rate_sel_e DEFAULT_SYMB_RATE_SEL           = SYMB_RATE_FULL
) (
    input  var logic       clk_mmi,
    input  var logic       sresetn_mmi,
    // Register port
    input  var mmi_req_t   mmi_req,
    output var logic       wready,
    output var logic       arready,
    input  var logic       rready,
    output var mmi_rsp_t   mmi_rsp,
    // Sample stream in
    input  var logic       s_valid,
    output var logic       s_ready,
    input  var iq_sample_t s_data,
    // Sample stream out
    output var logic       m_valid,
    input  var logic       m_ready,
    output var iq_sample_t m_data
);

    symb_cfg_t              symb_cfg;
    logic [MMI_DATA_NB-1:0] symb_count;

    ////////////////////////////////////////////////////////////
    // Configuration registers

    symb_rate_regs #(
        .SYMB_RATE_MSPS        ( SYMB_RATE_MSPS ),
        .DEFAULT_SYMB_RATE_SEL ( DEFAULT_SYMB_RATE_SEL )
    ) symb_rate_regs_inst (
        .clk_mmi     ( clk_mmi ),
        .sresetn_mmi ( sresetn_mmi ),
        .mmi_req     ( mmi_req ),
        .wready      ( wready ),
        .symb_cfg    ( symb_cfg )
    );

    // Sample path
    symb_repeater symb_repeater_inst (
        .clk_mmi     ( clk_mmi ),
        .sresetn_mmi ( sresetn_mmi ),
        .symb_cfg    ( symb_cfg ),
        .s_valid     ( s_valid ),
        .s_ready     ( s_ready ),
        .s_data      ( s_data ),
        .m_valid     ( m_valid ),
        .m_ready     ( m_ready ),
        .m_data      ( m_data ),
        .symb_count  ( symb_count )
    );

    // Read side
    mmi_read_resp mmi_read_resp_inst (
        .clk_mmi     ( clk_mmi ),
        .sresetn_mmi ( sresetn_mmi ),
        .mmi_req     ( mmi_req ),
        .arready     ( arready ),
        .rready      ( rready ),
        .symb_cfg    ( symb_cfg ),
        .symb_count  ( symb_count ),
        .mmi_rsp     ( mmi_rsp )
    );

endmodule

`default_nettype wire

// ==== logic/symb_rate_pkg.sv ====
////////////////////////////////////////////////////////////
// TX symbol rate stage shared types
////////////////////////////////////////////////////////////

`default_nettype none

package symb_rate_pkg;

    ////////////////////////////////////////////////////////////
    // Register port widths and constants

    localparam int MMI_DATA_NB = 32;
    localparam int MMI_ADDR_NB = 4;

    // Number of selectable symbol rates
    localparam int NUM_SYMB_RATES = 3;

    localparam logic [MMI_DATA_NB-1:0] MODULE_VERSION = 32'd1;

    ////////////////////////////////////////////////////////////
    // Enums

    // Rate index, also the register encoding
    typedef enum logic [1:0] {
        SYMB_RATE_QUARTER = 2'd0,
        SYMB_RATE_HALF    = 2'd1,
        SYMB_RATE_FULL    = 2'd2
    } symb_rate_sel_e;

    // Register word addresses
    typedef enum logic [MMI_ADDR_NB-1:0] {
        ADDR_MODULE_VERSION = 4'd0,
        ADDR_SYMB_RATE_SEL  = 4'd1,
        ADDR_SYMB_RATE      = 4'd2,
        ADDR_SYMB_COUNT     = 4'd3,
        TOTAL_MMI_REGS      = 4'd4
    } mmi_addr_e;

    ////////////////////////////////////////////////////////////
    // Structs

    // One cycle of register requests, write and read side
    typedef struct packed {
        logic                   wvalid;
        logic [MMI_ADDR_NB-1:0] waddr;
        logic [MMI_DATA_NB-1:0] wdata;
        logic                   arvalid;
        logic [MMI_ADDR_NB-1:0] raddr;
    } mmi_req_t;

    typedef struct packed {
        logic                   rvalid;
        logic [MMI_DATA_NB-1:0] rdata;
    } mmi_rsp_t;

    typedef struct packed {
        logic signed [15:0] i;
        logic signed [15:0] q;
    } iq_sample_t;

    // Live configuration, index and rate always move together
    typedef struct packed {
        symb_rate_sel_e         rate_sel;
        logic [MMI_DATA_NB-1:0] rate_msps;
    } symb_cfg_t;

endpackage

`default_nettype wire

// ==== logic/symb_rate_regs.sv ====
////////////////////////////////////////////////////////////
// Symbol rate configuration registers
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module symb_rate_regs
    import symb_rate_pkg::*;
#(
    parameter int             SYMB_RATE_MSPS [NUM_SYMB_RATES] = '{125, 250, 500},
    parameter symb_rate_sel_e DEFAULT_SYMB_RATE_SEL           = SYMB_RATE_FULL
) (
    input  var logic      clk_mmi,
    input  var logic      sresetn_mmi,
    input  var mmi_req_t  mmi_req,
    output var logic      wready,
    output var symb_cfg_t symb_cfg
);

    ////////////////////////////////////////////////////////////
    // Table lookups

    // Index to rate, unknown index gives zero
    function automatic logic [MMI_DATA_NB-1:0] sel_to_rate(input logic [1:0] sel);
        logic [MMI_DATA_NB-1:0] rate;
        rate = '0;
        for (int i = 0; i < NUM_SYMB_RATES; i++) begin
            if (sel == i[1:0]) begin
                rate = MMI_DATA_NB'(SYMB_RATE_MSPS[i]);
            end
        end
        return rate;
    endfunction

    // Rate to index, falls back to the default
    function automatic symb_rate_sel_e rate_to_sel(input logic [MMI_DATA_NB-1:0] rate);
        symb_rate_sel_e sel;
        sel = DEFAULT_SYMB_RATE_SEL;
        for (int i = 0; i < NUM_SYMB_RATES; i++) begin
            if (rate == MMI_DATA_NB'(SYMB_RATE_MSPS[i])) begin
                sel = symb_rate_sel_e'(i[1:0]);
            end
        end
        return sel;
    endfunction

    logic wr_en;

    // Writes accepted whenever out of reset
    assign wready = sresetn_mmi;
    assign wr_en  = mmi_req.wvalid && wready;

    ////////////////////////////////////////////////////////////
    // Write decode

    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            symb_cfg.rate_sel  <= DEFAULT_SYMB_RATE_SEL;
            symb_cfg.rate_msps <= sel_to_rate(DEFAULT_SYMB_RATE_SEL);
        end else if (wr_en) begin
            case (mmi_req.waddr)
                ADDR_SYMB_RATE_SEL: begin
                    // Index write, rate follows from the table
                    if (mmi_req.wdata < NUM_SYMB_RATES) begin
                        symb_cfg.rate_sel  <= symb_rate_sel_e'(mmi_req.wdata[1:0]);
                        symb_cfg.rate_msps <= sel_to_rate(mmi_req.wdata[1:0]);
                    end
                end
                ADDR_SYMB_RATE: begin
                    // Rate stored as written, index looked up
                    symb_cfg.rate_msps <= mmi_req.wdata;
                    symb_cfg.rate_sel  <= rate_to_sel(mmi_req.wdata);
                end
                default: begin
                    // Read-only or unmapped
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // Index never leaves the table range
    assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi)
        symb_cfg.rate_sel < NUM_SYMB_RATES);

endmodule

`default_nettype wire

// ==== logic/symb_repeater.sv ====
////////////////////////////////////////////////////////////
// Symbol repeater and counter
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module symb_repeater
    import symb_rate_pkg::*;
(
    input  var logic       clk_mmi,
    input  var logic       sresetn_mmi,
    input  var symb_cfg_t  symb_cfg,
    input  var logic       s_valid,
    output var logic       s_ready,
    input  var iq_sample_t s_data,
    output var logic       m_valid,
    input  var logic       m_ready,
    output var iq_sample_t m_data,
    output var logic [MMI_DATA_NB-1:0] symb_count
);

    // START keeps s_ready low for a cycle after reset
    typedef enum logic [1:0] {
        ST_START,
        ST_IDLE,
        ST_SEND
    } rep_state_e;

    // Copies per symbol for each rate
    function automatic logic [2:0] repeat_factor(input symb_rate_sel_e sel);
        case (sel)
            SYMB_RATE_QUARTER: return 3'd4;
            SYMB_RATE_HALF:    return 3'd2;
            default:           return 3'd1;
        endcase
    endfunction

    rep_state_e state;
    logic [2:0] rep_cnt;
    iq_sample_t hold_data;
    logic       last_copy;
    logic       accept;

    ////////////////////////////////////////////////////////////
    // Handshake

    assign last_copy = (state == ST_SEND) && (rep_cnt == 3'd1);
    // Refill when idle or as the last copy leaves
    assign s_ready   = (state == ST_IDLE) || (last_copy && m_ready);
    assign accept    = s_valid && s_ready;

    assign m_valid = (state == ST_SEND);
    assign m_data  = hold_data;

    ////////////////////////////////////////////////////////////
    // Repeat FSM

    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            state      <= ST_START;
            rep_cnt    <= 3'd0;
            symb_count <= '0;
        end else begin
            case (state)
                ST_START: state <= ST_IDLE;
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_SEND;
                        rep_cnt <= repeat_factor(symb_cfg.rate_sel);
                    end
                end
                ST_SEND: begin
                    if (accept) begin
                        // Back to back, factor sampled per symbol
                        rep_cnt <= repeat_factor(symb_cfg.rate_sel);
                    end else if (last_copy && m_ready) begin
                        state <= ST_IDLE;
                    end else if (m_ready) begin
                        rep_cnt <= rep_cnt - 3'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            // Wraps at 2^32
            if (accept) begin
                symb_count <= symb_count + 1'b1;
            end
        end
    end

    // Held symbol
    always_ff @(posedge clk_mmi) begin
        if (accept) begin
            hold_data <= s_data;
        end
    end

    // Output holds under back-pressure
    assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the symbol rate testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module symb_rate_tb \
    -Mdir obj_dir \
    -o symb_rate_sim

status=0
./obj_dir/symb_rate_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== sim.f ====
+incdir+tests
logic/symb_rate_pkg.sv
logic/symb_rate_regs.sv
logic/symb_repeater.sv
logic/mmi_read_resp.sv
logic/symb_rate_divider_top.sv
tests/symb_rate_tb.sv

// ==== tests/symb_rate_tb_tasks.svh ====
////////////////////////////////////////////////////////////
// Testbench register and stream tasks
////////////////////////////////////////////////////////////

`ifndef SYMB_RATE_TB_TASKS_SVH
`define SYMB_RATE_TB_TASKS_SVH

task automatic report_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errors++;
endtask

////////////////////////////////////////////////////////////
// Reference model

// Copies per symbol, quarter 4, half 2, full 1
function automatic int factor_for_sel(input int sel);
    case (sel)
        0:       return 4;
        1:       return 2;
        default: return 1;
    endcase
endfunction

// Tracks the rate index the DUT should hold
function automatic void model_write(input logic [3:0] addr, input logic [31:0] data);
    if (addr == ADDR_SYMB_RATE_SEL && data < 32'(NUM_SYMB_RATES)) begin
        model_sel = int'(data);
    end else if (addr == ADDR_SYMB_RATE) begin
        // Unknown rate falls back to the default index
        model_sel = int'(DEFAULT_SEL);
        for (int i = 0; i < NUM_SYMB_RATES; i++) begin
            if (data == 32'(RATE_TABLE[i])) begin
                model_sel = i;
            end
        end
    end
endfunction

////////////////////////////////////////////////////////////
// Register port

task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk_mmi);
    mmi_req.wvalid <= 1'b1;
    mmi_req.waddr  <= addr;
    mmi_req.wdata  <= data;
    @(negedge clk_mmi);
    while (!wready) @(negedge clk_mmi);
    // Write taken on this edge
    @(posedge clk_mmi);
    mmi_req.wvalid <= 1'b0;
    model_write(addr, data);
endtask

task automatic read_reg(input logic [3:0] addr, input logic [31:0] expected);
    @(posedge clk_mmi);
    mmi_req.arvalid <= 1'b1;
    mmi_req.raddr   <= addr;
    rready          <= 1'b1;
    @(negedge clk_mmi);
    while (!arready) @(negedge clk_mmi);
    @(posedge clk_mmi);
    mmi_req.arvalid <= 1'b0;
    // Response due exactly one cycle after the request
    @(negedge clk_mmi);
    if (!mmi_rsp.rvalid) begin
        report_error($sformatf("no read response one cycle after request to %0d", addr));
    end else if (mmi_rsp.rdata !== expected) begin
        report_error($sformatf("read %0d returned %0d, expected %0d",
                               addr, mmi_rsp.rdata, expected));
    end
endtask

// Read with rready held low for a while
task automatic read_held(input logic [3:0] addr, input logic [31:0] expected);
    @(posedge clk_mmi);
    mmi_req.arvalid <= 1'b1;
    mmi_req.raddr   <= addr;
    rready          <= 1'b0;
    @(negedge clk_mmi);
    while (!arready) @(negedge clk_mmi);
    @(posedge clk_mmi);
    mmi_req.arvalid <= 1'b0;
    repeat (5) begin
        @(negedge clk_mmi);
        if (!mmi_rsp.rvalid || mmi_rsp.rdata !== expected) begin
            report_error($sformatf("held response lost, rvalid %0b data %0d",
                                   mmi_rsp.rvalid, mmi_rsp.rdata));
        end
        if (arready) begin
            report_error("arready high while a response is pending");
        end
    end
    @(posedge clk_mmi);
    rready <= 1'b1;
    @(negedge clk_mmi);
    if (!arready) begin
        report_error("arready low after rready was given");
    end
    @(negedge clk_mmi);
    if (mmi_rsp.rvalid) begin
        report_error("rvalid still high after rready");
    end
endtask

////////////////////////////////////////////////////////////
// Sample stream

task automatic send_burst(input int len);
    iq_sample_t exp_q [$];
    iq_sample_t sym;
    iq_sample_t want;
    int         factor;
    int         total;
    int         seen;
    factor = factor_for_sel(model_sel);
    total  = len * factor;
    seen   = 0;
    fork
        // Source, expected copies queued before each symbol
        begin
            for (int n = 0; n < len; n++) begin
                sym = iq_sample_t'($urandom);
                repeat (factor) exp_q.push_back(sym);
                @(posedge clk_mmi);
                s_valid <= 1'b1;
                s_data  <= sym;
                @(negedge clk_mmi);
                while (!s_ready) @(negedge clk_mmi);
            end
            @(posedge clk_mmi);
            s_valid <= 1'b0;
        end
        // Sink with random stalls
        begin
            while (seen < total) begin
                @(posedge clk_mmi);
                m_ready <= ($urandom_range(3, 0) != 0);
                @(negedge clk_mmi);
                if (m_valid && m_ready) begin
                    seen++;
                    if (exp_q.size() == 0) begin
                        report_error("output sample with no symbol left to repeat");
                    end else begin
                        want = exp_q.pop_front();
                        if (m_data !== want) begin
                            report_error($sformatf("output %0d was %h, expected %h",
                                                   seen, m_data, want));
                        end
                    end
                end
            end
        end
    join
    @(posedge clk_mmi);
    m_ready <= 1'b1;
    // Nothing more may come out
    repeat (4) begin
        @(negedge clk_mmi);
        if (m_valid) begin
            report_error("extra output sample after burst");
        end
    end
endtask

`endif

// ==== tests/symb_rate_tb.sv ====
////////////////////////////////////////////////////////////
// Symbol rate divider testbench
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module symb_rate_tb
    import symb_rate_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    // Worst burst needs well under this many cycles
    localparam int CYCLES_PER_TEST = 600;

    // Rate table and default handed to the DUT
    localparam int             RATE_TABLE [NUM_SYMB_RATES] = '{125, 250, 500};
    localparam symb_rate_sel_e DEFAULT_SEL                 = SYMB_RATE_FULL;

    typedef enum logic [2:0] {
        OP_WR_SEL,
        OP_WR_RATE,
        OP_RD,
        OP_RD_HOLD,
        OP_BURST
    } test_op_e;

    // Value is write data or burst length
    typedef struct packed {
        test_op_e    op;
        logic [3:0]  addr;
        logic [31:0] value;
        logic [31:0] expected;
    } test_t;

    ////////////////////////////////////////////////////////////
    // Test table

    localparam int NUM_TESTS = 24;
    localparam test_t TESTS [NUM_TESTS] = '{
        // Reset values
        '{OP_RD,      ADDR_MODULE_VERSION, 32'd0,   32'd1},
        '{OP_RD,      ADDR_SYMB_RATE_SEL,  32'd0,   32'd2},
        '{OP_RD,      ADDR_SYMB_RATE,      32'd0,   32'd500},
        '{OP_RD,      ADDR_SYMB_COUNT,     32'd0,   32'd0},
        // Either register drives the other
        '{OP_WR_SEL,  ADDR_SYMB_RATE_SEL,  32'd0,   32'd0},
        '{OP_RD,      ADDR_SYMB_RATE,      32'd0,   32'd125},
        '{OP_WR_RATE, ADDR_SYMB_RATE,      32'd250, 32'd0},
        '{OP_RD,      ADDR_SYMB_RATE_SEL,  32'd0,   32'd1},
        // Unknown rate and bad index
        '{OP_WR_RATE, ADDR_SYMB_RATE,      32'd300, 32'd0},
        '{OP_RD,      ADDR_SYMB_RATE_SEL,  32'd0,   32'd2},
        '{OP_WR_SEL,  ADDR_SYMB_RATE_SEL,  32'd3,   32'd0},
        '{OP_RD,      ADDR_SYMB_RATE_SEL,  32'd0,   32'd2},
        '{OP_RD,      ADDR_SYMB_RATE,      32'd0,   32'd300},
        // Bursts, rate changed in between
        '{OP_WR_SEL,  ADDR_SYMB_RATE_SEL,  32'd0,   32'd0},
        '{OP_BURST,   4'd0,                32'd20,  32'd0},
        '{OP_WR_SEL,  ADDR_SYMB_RATE_SEL,  32'd1,   32'd0},
        '{OP_BURST,   4'd0,                32'd24,  32'd0},
        '{OP_WR_RATE, ADDR_SYMB_RATE,      32'd500, 32'd0},
        '{OP_BURST,   4'd0,                32'd30,  32'd0},
        '{OP_WR_SEL,  ADDR_SYMB_RATE_SEL,  32'd0,   32'd0},
        '{OP_BURST,   4'd0,                32'd9,   32'd0},
        // Count of all burst symbols, unmapped address, then a held response
        '{OP_RD,      ADDR_SYMB_COUNT,     32'd0,   32'd83},
        '{OP_RD,      4'd7,                32'd0,   32'd0},
        '{OP_RD_HOLD, ADDR_SYMB_COUNT,     32'd0,   32'd83}
    };

    logic       clk_mmi = 1'b0;
    logic       sresetn_mmi;
    mmi_req_t   mmi_req;
    logic       wready;
    logic       arready;
    logic       rready;
    mmi_rsp_t   mmi_rsp;
    logic       s_valid;
    logic       s_ready;
    iq_sample_t s_data;
    logic       m_valid;
    logic       m_ready;
    iq_sample_t m_data;

    int errors;
    int model_sel;

    `include "symb_rate_tb_tasks.svh"

    always #(CLK_PERIOD / 2) clk_mmi = ~clk_mmi;

    symb_rate_divider_top #(
        .SYMB_RATE_MSPS        ( RATE_TABLE ),
        .DEFAULT_SYMB_RATE_SEL ( DEFAULT_SEL )
    ) symb_rate_divider_top_inst (
        .clk_mmi     ( clk_mmi ),
        .sresetn_mmi ( sresetn_mmi ),
        .mmi_req     ( mmi_req ),
        .wready      ( wready ),
        .arready     ( arready ),
        .rready      ( rready ),
        .mmi_rsp     ( mmi_rsp ),
        .s_valid     ( s_valid ),
        .s_ready     ( s_ready ),
        .s_data      ( s_data ),
        .m_valid     ( m_valid ),
        .m_ready     ( m_ready ),
        .m_data      ( m_data )
    );

    ////////////////////////////////////////////////////////////
    // Table loop

    initial begin
        test_t    tc;
        test_op_e op;
        int       passed;
        int       failed;
        int       errors_before;
        void'($urandom(32'h3545));
        mmi_req     = '0;
        rready      = 1'b1;
        s_valid     = 1'b0;
        s_data      = '0;
        m_ready     = 1'b0;
        sresetn_mmi = 1'b0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        model_sel   = int'(DEFAULT_SEL);
        repeat (RESET_CYCLES) @(posedge clk_mmi);
        sresetn_mmi <= 1'b1;
        repeat (2) @(posedge clk_mmi);
        for (int t = 0; t < NUM_TESTS; t++) begin
            tc            = TESTS[t];
            op            = tc.op;
            errors_before = errors;
            case (op)
                OP_WR_SEL, OP_WR_RATE: write_reg(tc.addr, tc.value);
                OP_RD:                 read_reg(tc.addr, tc.expected);
                OP_RD_HOLD:            read_held(tc.addr, tc.expected);
                default:               send_burst(int'(tc.value));
            endcase
            if (errors == errors_before) begin
                passed++;
                $display("Test %0d %s: pass", t, op.name());
            end else begin
                failed++;
                $display("Test %0d %s: fail", t, op.name());
            end
        end
        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog, budget scales with table length
    initial begin
        #((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles",
                 RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
